// ==== histPkg.sv ====
`default_nettype none

package histPkg;

    // raw timestamp straight from the tdc
    localparam int TS_WIDTH = 10;

    // bin geometry, same count for coarse and fine histograms
    localparam int BIN_ADDR_WIDTH = 4;
    localparam int NUM_BINS = 16;

    // coarse bin is 64 codes wide, so top 4 timestamp bits
    localparam int COARSE_SHIFT = 6;

    // fine bin is 4 codes wide inside the 64-code window
    localparam int FINE_SHIFT = 2;

    // per-bin counter, saturates at all ones
    localparam int COUNT_WIDTH = 5;

    // accepted strobes per pass, in or out of window
    localparam int ACQ_SAMPLES = 16;
    localparam int ACQ_COUNT_WIDTH = 5;

    // which histogram is being built
    typedef enum logic {
        PHASE_COARSE,
        PHASE_FINE
    } hisPhaseE;

    // builder either takes samples or freezes counts for the scan
    typedef enum logic {
        BUILD_ACCUMULATE,
        BUILD_HOLD
    } builderStateE;

    // peak search engine
    typedef enum logic {
        FIND_IDLE,
        FIND_SCAN
    } finderStateE;

endpackage

`default_nettype wire

// ==== binMapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module binMapper
    import histPkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic [TS_WIDTH-1:0]       roughData,
    input  wire hisPhaseE                  hisPhase,
    input  wire logic                      peakDone,
    input  wire logic [BIN_ADDR_WIDTH-1:0] peakCH,
    output logic      [BIN_ADDR_WIDTH-1:0] binAddr,
    output logic                           inWindow
);

    // lower bound of the fine window
    logic [TS_WIDTH-1:0] windowBase;

    // distance from window base, wraps high when below the base
    logic [TS_WIDTH-1:0] fineOffset;

    // coarse and fine address candidates
    logic [BIN_ADDR_WIDTH-1:0] coarseAddr;
    logic [BIN_ADDR_WIDTH-1:0] fineAddr;

    // window membership, upper bound is implied by offset width
    logic fineHit;

    // window base follows the coarse peak at the end of a coarse pass
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            windowBase <= '0;
        end else if (peakDone && (hisPhase == PHASE_COARSE)) begin
            windowBase <= TS_WIDTH'(peakCH) << COARSE_SHIFT;
        end
    end

    // coarse bin is simply the top timestamp bits
    assign coarseAddr = BIN_ADDR_WIDTH'(roughData >> COARSE_SHIFT);

    assign fineOffset = roughData - windowBase;

    // below-base samples wrap to >= 64, so one check covers both bounds
    assign fineHit = ((fineOffset >> COARSE_SHIFT) == '0);

    // offset / 4 picks the fine bin, only meaningful when fineHit
    assign fineAddr = BIN_ADDR_WIDTH'(fineOffset >> FINE_SHIFT);

    // address and window select per phase
    always_comb begin
        if (hisPhase == PHASE_FINE) begin
            binAddr  = fineAddr;
            inWindow = fineHit;
        end else begin
            // coarse pass bins every sample
            binAddr  = coarseAddr;
            inWindow = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== histogramBuilder.sv ====
`timescale 1ns/1ps
`default_nettype none

module histogramBuilder
    import histPkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      wrEn,
    input  wire logic [BIN_ADDR_WIDTH-1:0] binAddr,
    input  wire logic                      inWindow,
    input  wire logic                      peakDone,
    input  wire logic [BIN_ADDR_WIDTH-1:0] readAddr,
    output logic      [COUNT_WIDTH-1:0]    binCount,
    output hisPhaseE                       hisPhase,
    output logic                           acqDone,
    output logic                           busy
);

    // one saturating counter per bin
    logic [COUNT_WIDTH-1:0] binCounts [NUM_BINS];

    // accepted strobes in this pass
    logic [ACQ_COUNT_WIDTH-1:0] sampleCount;

    builderStateE builderState;

    // strobe is taken only while accumulating
    logic accept;

    // the accepted strobe closes the pass
    logic lastSample;

    assign accept = wrEn && !busy;
    assign lastSample = (sampleCount == ACQ_COUNT_WIDTH'(ACQ_SAMPLES - 1));

    // busy is just the hold state
    assign busy = (builderState == BUILD_HOLD);

    // scan port, counts are frozen while it is read
    assign binCount = binCounts[readAddr];

    // state, phase and sample counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            builderState <= BUILD_ACCUMULATE;
            hisPhase     <= PHASE_COARSE;
            sampleCount  <= '0;
            acqDone      <= 1'b0;
        end else begin
            // single-cycle pulse
            acqDone <= 1'b0;
            case (builderState)
                BUILD_ACCUMULATE: begin
                    if (accept) begin
                        sampleCount <= sampleCount + 1'b1;
                        if (lastSample) begin
                            builderState <= BUILD_HOLD;
                            acqDone      <= 1'b1;
                        end
                    end
                end
                BUILD_HOLD: begin
                    // peak reported, start the other histogram
                    if (peakDone) begin
                        builderState <= BUILD_ACCUMULATE;
                        sampleCount  <= '0;
                        hisPhase     <= (hisPhase == PHASE_COARSE) ? PHASE_FINE
                                                                   : PHASE_COARSE;
                    end
                end
                default: begin
                    builderState <= BUILD_ACCUMULATE;
                end
            endcase
        end
    end

    // bin counters, cleared once the peak is out
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binCounts[i] <= '0;
            end
        end else if (busy && peakDone) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binCounts[i] <= '0;
            end
        end else if (accept && inWindow) begin
            // hold at full scale instead of wrapping
            if (binCounts[binAddr] != '1) begin
                binCounts[binAddr] <= binCounts[binAddr] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== peakFinder.sv ====
`timescale 1ns/1ps
`default_nettype none

module peakFinder
    import histPkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      acqDone,
    input  wire hisPhaseE                  hisPhase,
    input  wire logic [COUNT_WIDTH-1:0]    binCount,
    output logic      [BIN_ADDR_WIDTH-1:0] readAddr,
    output logic                           peakDone,
    output logic      [BIN_ADDR_WIDTH-1:0] peakCH,
    output logic      [BIN_ADDR_WIDTH-1:0] peakFH,
    output logic      [TS_WIDTH-1:0]       tofEstimate
);

    finderStateE finderState;

    // running maximum and where it sits
    logic [COUNT_WIDTH-1:0]    maxCount;
    logic [BIN_ADDR_WIDTH-1:0] maxIdx;

    // current bin beats the best so far, strict so ties keep lower index
    logic newMax;

    // final index including the bin being read on the last scan cycle
    logic [BIN_ADDR_WIDTH-1:0] winnerIdx;

    // last address of the sweep
    logic scanEnd;

    // centre of the winning fine bin on the raw timestamp scale
    logic [TS_WIDTH-1:0] tofNext;

    assign newMax = (binCount > maxCount);
    assign winnerIdx = newMax ? readAddr : maxIdx;
    assign scanEnd = (readAddr == BIN_ADDR_WIDTH'(NUM_BINS - 1));

    // coarse start + fine start + half a fine bin
    assign tofNext = (TS_WIDTH'(peakCH) << COARSE_SHIFT)
                   + (TS_WIDTH'(winnerIdx) << FINE_SHIFT)
                   + TS_WIDTH'((1 << FINE_SHIFT) >> 1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            finderState <= FIND_IDLE;
            readAddr    <= '0;
            maxCount    <= '0;
            maxIdx      <= '0;
            peakDone    <= 1'b0;
            peakCH      <= '0;
            peakFH      <= '0;
            tofEstimate <= '0;
        end else begin
            peakDone <= 1'b0;
            case (finderState)
                FIND_IDLE: begin
                    // histogram frozen, start sweep at bin 0
                    if (acqDone) begin
                        finderState <= FIND_SCAN;
                        readAddr    <= '0;
                        maxCount    <= '0;
                        maxIdx      <= '0;
                    end
                end
                FIND_SCAN: begin
                    if (newMax) begin
                        maxCount <= binCount;
                        maxIdx   <= readAddr;
                    end
                    if (scanEnd) begin
                        // results valid while peakDone is high
                        finderState <= FIND_IDLE;
                        readAddr    <= '0;
                        peakDone    <= 1'b1;
                        if (hisPhase == PHASE_COARSE) begin
                            peakCH <= winnerIdx;
                        end else begin
                            peakFH      <= winnerIdx;
                            tofEstimate <= tofNext;
                        end
                    end else begin
                        readAddr <= readAddr + 1'b1;
                    end
                end
                default: begin
                    finderState <= FIND_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== histTdcTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTdcTop
    import histPkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      arstN,
    input  wire logic                      wrEn,
    input  wire logic [TS_WIDTH-1:0]       roughData,
    output logic                           busy,
    output logic                           peakDone,
    output logic      [BIN_ADDR_WIDTH-1:0] peakCH,
    output logic      [BIN_ADDR_WIDTH-1:0] peakFH,
    output logic      [TS_WIDTH-1:0]       tofEstimate
);

    // decode to execute
    logic [BIN_ADDR_WIDTH-1:0] binAddr;
    logic                      inWindow;

    // execute to result
    logic [COUNT_WIDTH-1:0]    binCount;
    logic                      acqDone;
    hisPhaseE                  hisPhase;

    // result back to execute
    logic [BIN_ADDR_WIDTH-1:0] readAddr;

    // decode, timestamp to bin address
    binMapper uBinMapper (
        .clk      (clk),
        .arstN    (arstN),
        .roughData(roughData),
        .hisPhase (hisPhase),
        .peakDone (peakDone),
        .peakCH   (peakCH),
        .binAddr  (binAddr),
        .inWindow (inWindow)
    );

    // execute, counting and pass control
    histogramBuilder uHistogramBuilder (
        .clk     (clk),
        .arstN   (arstN),
        .wrEn    (wrEn),
        .binAddr (binAddr),
        .inWindow(inWindow),
        .peakDone(peakDone),
        .readAddr(readAddr),
        .binCount(binCount),
        .hisPhase(hisPhase),
        .acqDone (acqDone),
        .busy    (busy)
    );

    // result, peak search and time estimate
    peakFinder uPeakFinder (
        .clk        (clk),
        .arstN      (arstN),
        .acqDone    (acqDone),
        .hisPhase   (hisPhase),
        .binCount   (binCount),
        .readAddr   (readAddr),
        .peakDone   (peakDone),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .tofEstimate(tofEstimate)
    );

endmodule

`default_nettype wire

// ==== histTdc_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTdcProps
    import histPkg::*;
(
    input wire logic                clk,
    input wire logic                arstN,
    input wire logic                acqDone,
    input wire logic                busy,
    input wire logic                peakDone,
    input wire logic [TS_WIDTH-1:0] tofEstimate
);

    // number of assertion failures so far
    int assertFails = 0;

    // result strobe lasts one cycle
    peakDonePulse: assert property (@(posedge clk) disable iff (!arstN)
        peakDone |=> !peakDone)
        else begin
            assertFails++;
            $error("peakDone high for more than one cycle");
        end

    // first cycle out of reset takes samples
    busyAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !busy)
        else begin
            assertFails++;
            $error("busy high in the first cycle after reset");
        end

    // hold covers the whole scan and ends right after the result
    busyDuringScan: assert property (@(posedge clk) disable iff (!arstN)
        acqDone |-> (busy throughout peakDone[->1]) ##1 !busy)
        else begin
            assertFails++;
            $error("busy not held from acqDone to the cycle after peakDone");
        end

    // estimate only moves together with a result
    tofStable: assert property (@(posedge clk) disable iff (!arstN)
        !peakDone |-> $stable(tofEstimate))
        else begin
            assertFails++;
            $error("tofEstimate changed between peakDone pulses");
        end

endmodule

bind histTdcTop histTdcProps props (
    .clk        (clk),
    .arstN      (arstN),
    .acqDone    (acqDone),
    .busy       (busy),
    .peakDone   (peakDone),
    .tofEstimate(tofEstimate)
);

`default_nettype wire

// ==== histTdcTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module histTdcTb
    import histPkg::*;
();

    logic                      clk;
    logic                      arstN;
    logic                      wrEn;
    logic [TS_WIDTH-1:0]       roughData;
    logic                      busy;
    logic                      peakDone;
    logic [BIN_ADDR_WIDTH-1:0] peakCH;
    logic [BIN_ADDR_WIDTH-1:0] peakFH;
    logic [TS_WIDTH-1:0]       tofEstimate;

    // parsed case file, one entry per strobe or per expected result
    byte opKind [$];
    int  opA [$];
    int  opB [$];
    int  opC [$];

    int errorCount;
    int checkCount;
    int sampleTotal;
    int passTotal;
    int cycleLimit;
    int cycleCount;

    // accepted strobes in the running pass
    int passSamples;

    histTdcTop dut (
        .clk        (clk),
        .arstN      (arstN),
        .wrEn       (wrEn),
        .roughData  (roughData),
        .busy       (busy),
        .peakDone   (peakDone),
        .peakCH     (peakCH),
        .peakFH     (peakFH),
        .tofEstimate(tofEstimate)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkBin(input string name, input logic [BIN_ADDR_WIDTH-1:0] expected,
                            input logic [BIN_ADDR_WIDTH-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s expected 0x%0h got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic checkTs(input string name, input logic [TS_WIDTH-1:0] expected,
                           input logic [TS_WIDTH-1:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s expected 0x%0h got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error: %s expected 0x%0h got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // whole file up front, so the run length is known before the first edge
    task automatic readCases();
        int    fd;
        int    n;
        byte   kind;
        int    vals [8];
        string line;
        fd = $fopen("histCases.txt", "r");
        if (fd == 0) begin
            $display("could not open histCases.txt, no stimulus to run");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", kind,
                        vals[0], vals[1], vals[2], vals[3],
                        vals[4], vals[5], vals[6], vals[7]);
            if (kind == "S" || kind == "D") begin
                // one entry per strobe on the line
                for (int i = 0; i < n - 1; i++) begin
                    opKind.push_back(kind);
                    opA.push_back(vals[i]);
                    opB.push_back(0);
                    opC.push_back(0);
                    sampleTotal++;
                end
            end else if (kind == "C" || kind == "F") begin
                opKind.push_back(kind);
                opA.push_back(vals[0]);
                opB.push_back(vals[1]);
                opC.push_back(vals[2]);
                passTotal++;
            end else begin
                $display("unknown line kind in histCases.txt: %s", line);
                errorCount++;
            end
        end
        $fclose(fd);
    endtask

    // every task below starts and ends 1 ns after a rising edge
    task automatic sendSample(input logic [TS_WIDTH-1:0] value);
        // source holds off while the scan runs
        while (busy) begin
            @(posedge clk);
            #1;
        end
        wrEn      = 1'b1;
        roughData = value;
        @(posedge clk);
        #1;
        wrEn = 1'b0;
        passSamples++;
        // busy rises exactly on the 16th accepted strobe
        checkFlag("busy", passSamples == ACQ_SAMPLES, busy);
        if (passSamples == ACQ_SAMPLES) begin
            passSamples = 0;
        end
    endtask

    // strobe during the scan, must be ignored
    task automatic dropSample(input logic [TS_WIDTH-1:0] value);
        if (!busy) begin
            $display("drop strobe found busy low, so it would have been accepted");
            errorCount++;
        end else begin
            wrEn      = 1'b1;
            roughData = value;
            @(posedge clk);
            #1;
            wrEn = 1'b0;
        end
    endtask

    task automatic waitPeak(input byte kind, input int ch, input int fh, input int tof);
        int waited;
        waited = 0;
        // scan is 17 cycles, leave some slack
        while (!peakDone && waited < NUM_BINS + 8) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!peakDone) begin
            $display("no peakDone within %0d cycles after the end of a pass", waited);
            errorCount++;
        end else begin
            checkBin("peakCH", BIN_ADDR_WIDTH'(ch), peakCH);
            if (kind == "F") begin
                checkBin("peakFH", BIN_ADDR_WIDTH'(fh), peakFH);
                checkTs("tofEstimate", TS_WIDTH'(tof), tofEstimate);
            end
        end
    endtask

    task automatic checkResetState();
        checkFlag("busy", 1'b0, busy);
        checkFlag("peakDone", 1'b0, peakDone);
        checkBin("peakCH", '0, peakCH);
        checkBin("peakFH", '0, peakFH);
        checkTs("tofEstimate", '0, tofEstimate);
    endtask

    initial begin
        errorCount  = 0;
        checkCount  = 0;
        sampleTotal = 0;
        passTotal   = 0;
        passSamples = 0;
        arstN       = 1'b0;
        wrEn        = 1'b0;
        roughData   = '0;
        readCases();
        // two cycles per strobe, 40 per pass
        cycleLimit = sampleTotal * 2 + passTotal * 40;
        repeat (5) @(posedge clk);
        #1;
        arstN = 1'b1;
        checkResetState();
        for (int i = 0; i < opKind.size(); i++) begin
            case (opKind[i])
                "S": begin
                    sendSample(TS_WIDTH'(opA[i]));
                end
                "D": begin
                    dropSample(TS_WIDTH'(opA[i]));
                end
                default: begin
                    waitPeak(opKind[i], opA[i], opB[i], opC[i]);
                end
            endcase
        end
        // bound assertion failures count as errors
        errorCount += dut.props.assertFails;
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog on the clock
    initial begin
        cycleCount = 0;
        wait (cycleLimit != 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== histCases.txt ====
# S v...       : strobes to send, hex timestamps, one or more per line
# D v...       : strobes given while busy is high, must be dropped
# C ch         : expected coarse result, F ch fh tof : expected fine result (hex)
#
# pass 1 coarse, 10 of 16 in coarse bin 5, neighbours 13f and 180 once each
S 140 15a 17f 000 163 145 3ff 170
S 0c5 150 13f 166 180 158 2a0 17e
C 5
#
# pass 2 fine, window 140..17f, fine bin 9 five times
# six strobes outside the window would win bin 0 if they were binned
S 164 180 148 165 181 17c 166 182
S 14a 183 167 1c0 14b 164 100 17f
# strobes in coarse bin 11 during the scan, would break the tie below
D 2d0 2d4
F 5 9 166
#
# pass 3 coarse, 8 in bin 11 and 8 in bin 3, tie keeps bin 3
S 2c0 0c0 2ff 0ff 2d0 0d8 2e4 0f3
S 2f8 0f0 2c7 0c1 2e0 0fb 2fe 0da
C 3
#
# pass 4 fine, window 0c0..0ff, bins 6 and 12 tie at four
# 0bf and 100 lie outside and would lift bin 0 to four if binned
S 0f0 0d8 0c0 0f8 0f1 0d9 0bf 0c1
S 0f2 0da 0f9 100 0c2 0f3 0db 0fa
F 3 6 0da

// ==== flist.f ====
histPkg.sv
binMapper.sv
histogramBuilder.sv
peakFinder.sv
histTdcTop.sv
histTdc_props.sv
histTdcTb.sv
